/* dma_params.svh */
// DMA frontend parameters
// shared widths, job queue depth and accelerator opcode match patterns

`ifndef DMA_PARAMS_SVH
`define DMA_PARAMS_SVH

// datapath widths
`define DMA_ADDR_WIDTH   32
`define DMA_REP_WIDTH    32
`define DMA_TF_ID_WIDTH  32
`define DMA_ACC_ID_WIDTH 5

// number of 2D jobs queued ahead of the midend
`define DMA_FIFO_DEPTH   3

// opcode patterns, ? marks register or immediate fields
`define DMA_OP_DMSRC   32'b0000000_?????_?????_000_00000_0101011
`define DMA_OP_DMDST   32'b0000001_?????_?????_000_00000_0101011
`define DMA_OP_DMCPYI  32'b0000010_?????_?????_000_?????_0101011
`define DMA_OP_DMCPY   32'b0000011_?????_?????_000_?????_0101011
`define DMA_OP_DMSTATI 32'b0000100_?????_?????_000_?????_0101011
`define DMA_OP_DMSTAT  32'b0000101_?????_?????_000_?????_0101011
`define DMA_OP_DMSTR   32'b0000110_?????_?????_000_00000_0101011
`define DMA_OP_DMREP   32'b0000111_?????_?????_000_00000_0101011

`endif

/* acc_pkg.sv */
// Accelerator bus types
// request and response payloads of the accelerator interface, the op word
// with its two decodings and the status selector

`include "dma_params.svh"

package acc_pkg;

    // immediate view of the op word
    typedef struct packed {
        logic [6:0] funct7;
        logic [2:0] chan;
        logic [1:0] imm_cfg;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } acc_op_fields_t;

    // raw view is matched against opcodes, field view yields immediates
    typedef union packed {
        logic [31:0]    raw;
        acc_op_fields_t fields;
    } acc_op_t;

    typedef struct packed {
        logic [`DMA_ACC_ID_WIDTH-1:0] id;
        acc_op_t                      op;
        logic [31:0]                  arga;
        logic [31:0]                  argb;
    } acc_req_t;

    typedef struct packed {
        logic [`DMA_ACC_ID_WIDTH-1:0] id;
        logic [31:0]                  data;
        logic                         error;
    } acc_res_t;

    typedef enum logic [1:0] {
        STAT_COMPLETED_ID = 2'd0,
        STAT_NEXT_ID      = 2'd1,
        STAT_BUSY         = 2'd2,
        STAT_FULL         = 2'd3
    } status_sel_t;

endpackage

/* dma_pkg.sv */
// DMA job types
// 1D burst request handed to the backend, the 2D job queued by the
// decoder and the copy configuration bits

`include "dma_params.svh"

package dma_pkg;

    // one contiguous transfer
    typedef struct packed {
        logic [`DMA_ADDR_WIDTH-1:0] src_addr;
        logic [`DMA_ADDR_WIDTH-1:0] dst_addr;
        logic [`DMA_ADDR_WIDTH-1:0] length;
    } burst_req_t;

    // burst repeated reps times with per-repetition strides
    typedef struct packed {
        burst_req_t                burst;
        logic [`DMA_REP_WIDTH-1:0] src_stride;
        logic [`DMA_REP_WIDTH-1:0] dst_stride;
        logic [`DMA_REP_WIDTH-1:0] reps;
    } nd_job_t;

    // copy config from argb or the immediate
    typedef struct packed {
        logic twod;
        logic rsvd;
    } copy_cfg_t;

endpackage

/* dma_inst_decoder.sv */
// DMA instruction decoder
// decodes accelerator bus DMA instructions, keeps the staged job registers
// and sequences the request, job and response handshakes

`timescale 1ns/100ps
`include "dma_params.svh"

module dma_inst_decoder (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  acc_pkg::acc_req_t           acc_req_i,
    input  logic                        acc_req_valid_i,
    output logic                        acc_req_ready_o,
    output dma_pkg::nd_job_t            job_o,
    output logic                        job_valid_o,
    input  logic                        job_ready_i,
    output acc_pkg::acc_res_t           res_o,
    output logic                        res_valid_o,
    input  logic                        res_ready_i,
    input  logic [`DMA_TF_ID_WIDTH-1:0] next_id_i,
    input  logic [`DMA_TF_ID_WIDTH-1:0] completed_id_i,
    input  logic                        busy_i
);

    dma_pkg::nd_job_t      job_d, job_q;
    dma_pkg::copy_cfg_t    cfg;
    acc_pkg::status_sel_t  stat_sel;

    // --------------------------------------------------------------------------
    // decode
    // --------------------------------------------------------------------------
    always_comb begin
        job_d           = job_q;
        cfg             = '0;
        stat_sel        = acc_pkg::STAT_COMPLETED_ID;
        job_valid_o     = 1'b0;
        acc_req_ready_o = 1'b0;
        res_valid_o     = 1'b0;
        res_o           = '0;
        res_o.id        = acc_req_i.id;
        res_o.error     = 1'b1;

        if (acc_req_valid_i) begin
            unique casez (acc_req_i.op.raw)
                `DMA_OP_DMSRC: begin
                    job_d.burst.src_addr = acc_req_i.arga;
                    acc_req_ready_o      = 1'b1;
                end
                `DMA_OP_DMDST: begin
                    job_d.burst.dst_addr = acc_req_i.arga;
                    acc_req_ready_o      = 1'b1;
                end
                `DMA_OP_DMSTR: begin
                    job_d.src_stride = acc_req_i.arga;
                    job_d.dst_stride = acc_req_i.argb;
                    acc_req_ready_o  = 1'b1;
                end
                `DMA_OP_DMREP: begin
                    job_d.reps      = acc_req_i.arga;
                    acc_req_ready_o = 1'b1;
                end
                `DMA_OP_DMCPYI, `DMA_OP_DMCPY: begin
                    if (acc_req_i.op.raw ==? `DMA_OP_DMCPYI) begin
                        cfg = acc_req_i.op.fields.imm_cfg;
                    end else begin
                        cfg = acc_req_i.argb[1:0];
                    end
                    job_d.burst.length = acc_req_i.arga;
                    // push only with room for the response, ack with the push
                    if (res_ready_i) begin
                        job_valid_o = 1'b1;
                        if (job_ready_i) begin
                            res_o.data      = next_id_i;
                            res_o.error     = 1'b0;
                            res_valid_o     = 1'b1;
                            acc_req_ready_o = 1'b1;
                        end
                    end
                end
                `DMA_OP_DMSTATI, `DMA_OP_DMSTAT: begin
                    if (acc_req_i.op.raw ==? `DMA_OP_DMSTATI) begin
                        stat_sel = acc_pkg::status_sel_t'(acc_req_i.op.fields.imm_cfg);
                    end else begin
                        stat_sel = acc_pkg::status_sel_t'(acc_req_i.argb[1:0]);
                    end
                    case (stat_sel)
                        acc_pkg::STAT_COMPLETED_ID: res_o.data = completed_id_i;
                        acc_pkg::STAT_NEXT_ID:      res_o.data = next_id_i;
                        acc_pkg::STAT_BUSY:         res_o.data = {31'd0, busy_i};
                        default:                    res_o.data = {31'd0, !job_ready_i};
                    endcase
                    res_o.error = 1'b0;
                    if (res_ready_i) begin
                        res_valid_o     = 1'b1;
                        acc_req_ready_o = 1'b1;
                    end
                end
                // unknown ops are never acknowledged
                default: ;
            endcase
        end
    end

    // 1D copies ignore the programmed repetition count
    always_comb begin
        job_o = job_d;
        if (!cfg.twod) begin
            job_o.reps = 1;
        end
    end

    // staged job persists between copies
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            job_q <= '0;
        end else begin
            job_q <= job_d;
        end
    end

endmodule

/* dma_req_fifo.sv */
// DMA request FIFO
// circular buffer queueing jobs between producer and consumer, registered
// storage with a fill count

`timescale 1ns/100ps
`include "dma_params.svh"

module dma_req_fifo #(
    parameter int unsigned DEPTH = `DMA_FIFO_DEPTH,
    parameter type         T     = dma_pkg::nd_job_t
) (
    input  logic clk_i,
    input  logic rst_n_i,
    input  T     data_i,
    input  logic valid_i,
    output logic ready_o,
    output T     data_o,
    output logic valid_o,
    input  logic ready_i,
    output logic full_o,
    output logic empty_o
);

    localparam int unsigned PtrWidth = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CntWidth = $clog2(DEPTH + 1);

    T                    mem_q [DEPTH];
    logic [PtrWidth-1:0] wr_ptr_q, rd_ptr_q;
    logic [CntWidth-1:0] count_q;
    logic                push, pop;

    assign full_o  = (count_q == CntWidth'(DEPTH));
    assign empty_o = (count_q == '0);
    assign ready_o = !full_o;
    assign valid_o = !empty_o;
    assign data_o  = mem_q[rd_ptr_q];
    assign push    = valid_i && ready_o;
    assign pop     = valid_o && ready_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PtrWidth'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PtrWidth'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q <= count_q + CntWidth'(push) - CntWidth'(pop);
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

endmodule

/* dma_nd_midend.sv */
// DMA 2D midend
// expands each 2D job into strided 1D bursts and retires the job once the
// backend has reported all of its bursts done

`timescale 1ns/100ps
`include "dma_params.svh"

module dma_nd_midend (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  dma_pkg::nd_job_t    job_i,
    input  logic                job_valid_i,
    output logic                job_ready_o,
    output dma_pkg::burst_req_t burst_req_o,
    output logic                burst_valid_o,
    input  logic                burst_ready_i,
    input  logic                burst_done_i,
    output logic                retire_o,
    output logic                busy_o
);

    dma_pkg::nd_job_t           job_q;
    logic                       active_q;
    logic [`DMA_REP_WIDTH-1:0]  rep_q, done_q, cq_count;
    logic [`DMA_ADDR_WIDTH-1:0] src_q, dst_q;
    logic                       burst_hs, last_burst, load;
    logic                       cq_ready, cq_valid;

    assign burst_valid_o        = active_q;
    assign burst_req_o.src_addr = src_q;
    assign burst_req_o.dst_addr = dst_q;
    assign burst_req_o.length   = job_q.burst.length;

    assign burst_hs   = burst_valid_o && burst_ready_i;
    assign last_burst = burst_hs && (rep_q == job_q.reps - 1'b1);
    // next job loads with the last burst of the current one
    assign job_ready_o = (!active_q || last_burst) && cq_ready;
    assign load        = job_valid_i && job_ready_o;

    // rep counts of jobs still waiting for done pulses
    dma_req_fifo #(
        .DEPTH ( `DMA_FIFO_DEPTH                ),
        .T     ( logic [`DMA_REP_WIDTH-1:0]     )
    ) i_cnt_queue (
        .clk_i   ( clk_i      ),
        .rst_n_i ( rst_n_i    ),
        .data_i  ( job_i.reps ),
        .valid_i ( load       ),
        .ready_o ( cq_ready   ),
        .data_o  ( cq_count   ),
        .valid_o ( cq_valid   ),
        .ready_i ( retire_o   ),
        .full_o  (            ),
        .empty_o (            )
    );

    assign retire_o = cq_valid && burst_done_i && (done_q == cq_count - 1'b1);
    assign busy_o   = cq_valid;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            active_q <= 1'b0;
            rep_q    <= '0;
            done_q   <= '0;
        end else begin
            if (load) begin
                active_q <= 1'b1;
                rep_q    <= '0;
            end else if (last_burst) begin
                active_q <= 1'b0;
            end else if (burst_hs) begin
                rep_q <= rep_q + 1'b1;
            end
            if (retire_o) begin
                done_q <= '0;
            end else if (burst_done_i) begin
                done_q <= done_q + 1'b1;
            end
        end
    end

    // running addresses advance by the strides after each burst
    always_ff @(posedge clk_i) begin
        if (load) begin
            job_q <= job_i;
            src_q <= job_i.burst.src_addr;
            dst_q <= job_i.burst.dst_addr;
        end else if (burst_hs) begin
            src_q <= src_q + job_q.src_stride;
            dst_q <= dst_q + job_q.dst_stride;
        end
    end

endmodule

/* dma_tf_id_gen.sv */
// Transfer ID generator
// hands out the next transfer ID and tracks the last completed one

`timescale 1ns/100ps
`include "dma_params.svh"

module dma_tf_id_gen (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        issue_i,
    input  logic                        retire_i,
    output logic [`DMA_TF_ID_WIDTH-1:0] next_o,
    output logic [`DMA_TF_ID_WIDTH-1:0] completed_o
);

    // ID 0 means nothing completed yet
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            next_o      <= `DMA_TF_ID_WIDTH'(1);
            completed_o <= '0;
        end else begin
            if (issue_i) begin
                next_o <= next_o + 1'b1;
            end
            if (retire_i) begin
                completed_o <= completed_o + 1'b1;
            end
        end
    end

endmodule

/* dma_rsp_spill.sv */
// Response spill register
// two-entry buffer with registered outputs that cuts the ready path from
// the accelerator bus back into the decoder

`timescale 1ns/100ps

module dma_rsp_spill (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  acc_pkg::acc_res_t data_i,
    input  logic              valid_i,
    output logic              ready_o,
    output acc_pkg::acc_res_t data_o,
    output logic              valid_o,
    input  logic              ready_i
);

    acc_pkg::acc_res_t a_data_q, b_data_q;
    logic              a_full_q, b_full_q;
    logic              a_fill, a_drain, b_fill, b_drain;

    // a takes new data, b catches a when the output stalls
    assign a_fill  = valid_i && ready_o;
    assign a_drain = a_full_q && !b_full_q;
    assign b_fill  = a_drain && !ready_i;
    assign b_drain = b_full_q && ready_i;

    assign ready_o = !a_full_q || !b_full_q;
    assign valid_o = a_full_q || b_full_q;
    assign data_o  = b_full_q ? b_data_q : a_data_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            a_full_q <= 1'b0;
            b_full_q <= 1'b0;
        end else begin
            if (a_fill || a_drain) begin
                a_full_q <= a_fill;
            end
            if (b_fill || b_drain) begin
                b_full_q <= b_fill;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (a_fill) begin
            a_data_q <= data_i;
        end
        if (b_fill) begin
            b_data_q <= a_data_q;
        end
    end

endmodule

/* dma_frontend_top.sv */
// DMA frontend top level
// connects decoder, job FIFO, 2D midend, ID generator and response spill
// register of the tightly coupled single channel DMA frontend

`timescale 1ns/100ps
`include "dma_params.svh"

module dma_frontend_top (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  acc_pkg::acc_req_t   acc_req_i,
    input  logic                acc_req_valid_i,
    output logic                acc_req_ready_o,
    output acc_pkg::acc_res_t   acc_res_o,
    output logic                acc_res_valid_o,
    input  logic                acc_res_ready_i,
    output dma_pkg::burst_req_t burst_req_o,
    output logic                burst_valid_o,
    input  logic                burst_ready_i,
    input  logic                burst_done_i,
    output logic                busy_o
);

    dma_pkg::nd_job_t            dec_job, fifo_job;
    logic                        dec_job_valid, dec_job_ready;
    logic                        fifo_job_valid, fifo_job_ready, fifo_empty;
    acc_pkg::acc_res_t           dec_res;
    logic                        dec_res_valid, dec_res_ready;
    logic [`DMA_TF_ID_WIDTH-1:0] next_id, completed_id;
    logic                        issue, retire, mid_busy;

    // an ID is consumed by every job pushed into the queue
    assign issue  = dec_job_valid && dec_job_ready;
    assign busy_o = !fifo_empty || mid_busy;

    dma_inst_decoder i_decoder (
        .clk_i           ( clk_i           ),
        .rst_n_i         ( rst_n_i         ),
        .acc_req_i       ( acc_req_i       ),
        .acc_req_valid_i ( acc_req_valid_i ),
        .acc_req_ready_o ( acc_req_ready_o ),
        .job_o           ( dec_job         ),
        .job_valid_o     ( dec_job_valid   ),
        .job_ready_i     ( dec_job_ready   ),
        .res_o           ( dec_res         ),
        .res_valid_o     ( dec_res_valid   ),
        .res_ready_i     ( dec_res_ready   ),
        .next_id_i       ( next_id         ),
        .completed_id_i  ( completed_id    ),
        .busy_i          ( busy_o          )
    );

    dma_req_fifo i_req_fifo (
        .clk_i   ( clk_i          ),
        .rst_n_i ( rst_n_i        ),
        .data_i  ( dec_job        ),
        .valid_i ( dec_job_valid  ),
        .ready_o ( dec_job_ready  ),
        .data_o  ( fifo_job       ),
        .valid_o ( fifo_job_valid ),
        .ready_i ( fifo_job_ready ),
        .full_o  (                ),
        .empty_o ( fifo_empty     )
    );

    dma_nd_midend i_nd_midend (
        .clk_i         ( clk_i          ),
        .rst_n_i       ( rst_n_i        ),
        .job_i         ( fifo_job       ),
        .job_valid_i   ( fifo_job_valid ),
        .job_ready_o   ( fifo_job_ready ),
        .burst_req_o   ( burst_req_o    ),
        .burst_valid_o ( burst_valid_o  ),
        .burst_ready_i ( burst_ready_i  ),
        .burst_done_i  ( burst_done_i   ),
        .retire_o      ( retire         ),
        .busy_o        ( mid_busy       )
    );

    dma_tf_id_gen i_tf_id_gen (
        .clk_i       ( clk_i        ),
        .rst_n_i     ( rst_n_i      ),
        .issue_i     ( issue        ),
        .retire_i    ( retire       ),
        .next_o      ( next_id      ),
        .completed_o ( completed_id )
    );

    dma_rsp_spill i_rsp_spill (
        .clk_i   ( clk_i           ),
        .rst_n_i ( rst_n_i         ),
        .data_i  ( dec_res         ),
        .valid_i ( dec_res_valid   ),
        .ready_o ( dec_res_ready   ),
        .data_o  ( acc_res_o       ),
        .valid_o ( acc_res_valid_o ),
        .ready_i ( acc_res_ready_i )
    );

endmodule

/* tb_clk_gen.sv */
// Testbench clock and reset
// free running clock, active low reset held for the first two cycles

`timescale 1ns/100ps

module tb_clk_gen #(
    parameter int PERIOD_NS = 8
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o   = 1'b0;
        rst_n_o = 1'b0;
        repeat (2) @(posedge clk_o);
        // release away from the sampling edge
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

    always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

/* tb_dma_frontend.sv */
// DMA frontend testbench
// drives accelerator instructions, models the burst backend and checks
// bursts and responses against a reference model

`timescale 1ns/100ps
`include "dma_params.svh"

module tb_dma_frontend;

    localparam int TIMEOUT = 300;

    localparam logic [6:0] OP_SRC   = 7'd0;
    localparam logic [6:0] OP_DST   = 7'd1;
    localparam logic [6:0] OP_CPYI  = 7'd2;
    localparam logic [6:0] OP_CPY   = 7'd3;
    localparam logic [6:0] OP_STATI = 7'd4;
    localparam logic [6:0] OP_STAT  = 7'd5;
    localparam logic [6:0] OP_STR   = 7'd6;
    localparam logic [6:0] OP_REP   = 7'd7;

    logic                clk, rst_n;
    acc_pkg::acc_req_t   acc_req;
    logic                acc_req_valid, acc_req_ready;
    acc_pkg::acc_res_t   acc_res;
    logic                acc_res_valid;
    logic                acc_res_ready;
    dma_pkg::burst_req_t burst_req;
    logic                burst_valid;
    logic                burst_ready = 1'b0;
    logic                burst_done  = 1'b0;
    logic                busy;

    integer      seed       = 32'h38e5;
    bit          burst_hold = 1'b0;
    int unsigned cycle      = 0;
    int unsigned last_due   = 0;
    int unsigned done_cnt   = 0;
    logic [4:0]  tag;

    // reference model state
    dma_pkg::nd_job_t    mdl_job;
    logic [31:0]         mdl_next_id, mdl_completed;
    int                  mdl_queued;
    dma_pkg::burst_req_t exp_bursts[$];
    acc_pkg::acc_res_t   exp_res[$];
    int unsigned         job_bursts[$];
    int unsigned         done_due[$];

    // output stability tracking
    bit                  burst_stall = 1'b0;
    bit                  res_stall   = 1'b0;
    dma_pkg::burst_req_t held_burst;
    acc_pkg::acc_res_t   held_res;

    tb_clk_gen #(.PERIOD_NS(8)) clk_gen_inst (
        .clk_o   ( clk   ),
        .rst_n_o ( rst_n )
    );

    dma_frontend_top dma_frontend_top_inst (
        .clk_i           ( clk           ),
        .rst_n_i         ( rst_n         ),
        .acc_req_i       ( acc_req       ),
        .acc_req_valid_i ( acc_req_valid ),
        .acc_req_ready_o ( acc_req_ready ),
        .acc_res_o       ( acc_res       ),
        .acc_res_valid_o ( acc_res_valid ),
        .acc_res_ready_i ( acc_res_ready ),
        .burst_req_o     ( burst_req     ),
        .burst_valid_o   ( burst_valid   ),
        .burst_ready_i   ( burst_ready   ),
        .burst_done_i    ( burst_done    ),
        .busy_o          ( busy          )
    );

    // ------------------------------------------------------------------------
    // error reporting
    // ------------------------------------------------------------------------
    task automatic stop_run();
        $display("ERRORS FOUND");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic value_error(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        $display("ERR %s: got 0x%0h expected 0x%0h", name, got, exp);
        stop_run();
    endtask

    task automatic plain_error(input string what);
        $display("%s", what);
        stop_run();
    endtask

    // ------------------------------------------------------------------------
    // reference functions
    // ------------------------------------------------------------------------
    // burst k of a strided job
    function automatic dma_pkg::burst_req_t strided_burst(input dma_pkg::nd_job_t job,
                                                          input logic [31:0] k);
        dma_pkg::burst_req_t b;
        b.src_addr = job.burst.src_addr + k * job.src_stride;
        b.dst_addr = job.burst.dst_addr + k * job.dst_stride;
        b.length   = job.burst.length;
        return b;
    endfunction

    function automatic logic [31:0] expected_status(input logic [1:0] sel);
        case (sel)
            2'd0:    return mdl_completed;
            2'd1:    return mdl_next_id;
            2'd2:    return {31'd0, mdl_completed != mdl_next_id - 1};
            default: return {31'd0, mdl_queued >= `DMA_FIFO_DEPTH};
        endcase
    endfunction

    function automatic logic [31:0] make_op(input logic [6:0] funct7, input logic [1:0] imm);
        acc_pkg::acc_op_t op;
        op.raw            = {funct7, 5'd0, 5'd0, 3'b000, 5'd0, 7'b0101011};
        op.fields.imm_cfg = imm;
        // channel select must be ignored
        op.fields.chan    = 3'd5;
        return op.raw;
    endfunction

    // ------------------------------------------------------------------------
    // accelerator request side called on a falling edge
    // ------------------------------------------------------------------------
    task automatic issue_req(input logic [6:0] funct7, input logic [1:0] imm,
                             input logic [31:0] arga, input logic [31:0] argb,
                             input int max_cycles, output bit acked);
        int n;
        acc_req.id     = tag;
        acc_req.op.raw = make_op(funct7, imm);
        acc_req.arga   = arga;
        acc_req.argb   = argb;
        acc_req_valid  = 1'b1;
        acked          = 1'b0;
        n              = 0;
        while (!acked && n < max_cycles) begin
            @(posedge clk);
            acked = acc_req_ready;
            n++;
        end
        @(negedge clk);
        acc_req_valid = 1'b0;
        tag           = tag + 1'b1;
    endtask

    // acknowledged instruction plus the model update it implies
    task automatic instr(input logic [6:0] funct7, input logic [1:0] imm,
                         input logic [31:0] arga, input logic [31:0] argb);
        bit                acked;
        logic [4:0]        req_id;
        logic              twod;
        dma_pkg::nd_job_t  job;
        acc_pkg::acc_res_t r;
        req_id = tag;
        issue_req(funct7, imm, arga, argb, TIMEOUT, acked);
        assert (acked) else plain_error("instruction was never acknowledged");
        r.id    = req_id;
        r.error = 1'b0;
        case (funct7)
            OP_SRC: mdl_job.burst.src_addr = arga;
            OP_DST: mdl_job.burst.dst_addr = arga;
            OP_STR: begin
                mdl_job.src_stride = arga;
                mdl_job.dst_stride = argb;
            end
            OP_REP: mdl_job.reps = arga;
            OP_CPY, OP_CPYI: begin
                job              = mdl_job;
                job.burst.length = arga;
                twod             = (funct7 == OP_CPYI) ? imm[1] : argb[1];
                if (!twod) begin
                    job.reps = 1;
                end
                for (int k = 0; k < job.reps; k++) begin
                    exp_bursts.push_back(strided_burst(job, k));
                end
                job_bursts.push_back(job.reps);
                r.data = mdl_next_id;
                exp_res.push_back(r);
                mdl_next_id++;
            end
            default: begin
                r.data = expected_status((funct7 == OP_STATI) ? imm : argb[1:0]);
                exp_res.push_back(r);
            end
        endcase
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        @(posedge clk);
        while ((exp_bursts.size() > 0 || done_due.size() > 0 || exp_res.size() > 0 || busy)
               && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (n >= TIMEOUT) begin
            plain_error("timeout waiting for the DMA to drain");
        end
        @(negedge clk);
    endtask

    // ------------------------------------------------------------------------
    // backend model driven on the falling edge
    // ------------------------------------------------------------------------
    always @(negedge clk) begin
        if (rst_n !== 1'b1) begin
            burst_ready = 1'b0;
            burst_done  = 1'b0;
        end else begin
            burst_ready = burst_hold ? 1'b0 : (($random(seed) & 3) != 0);
            burst_done  = 1'b0;
            if (done_due.size() > 0 && done_due[0] <= cycle) begin
                void'(done_due.pop_front());
                burst_done = 1'b1;
                done_cnt++;
                // job retires with its last done pulse
                if (done_cnt == job_bursts[0]) begin
                    void'(job_bursts.pop_front());
                    done_cnt = 0;
                    mdl_completed++;
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // checker
    // ------------------------------------------------------------------------
    always @(posedge clk) begin
        dma_pkg::burst_req_t exp_b;
        acc_pkg::acc_res_t   exp_r;
        int unsigned         due;
        cycle = cycle + 1;
        if (rst_n === 1'b1) begin
            if (burst_stall) begin
                assert (burst_valid) else plain_error("burst_valid_o dropped while stalled");
                assert (burst_req == held_burst)
                    else value_error("burst_req_o", burst_req, held_burst);
            end
            if (res_stall) begin
                assert (acc_res_valid) else plain_error("acc_res_valid_o dropped while stalled");
                assert (acc_res == held_res) else value_error("acc_res_o", acc_res, held_res);
            end
            if (burst_valid && burst_ready) begin
                assert (exp_bursts.size() > 0) else plain_error("unexpected burst issued");
                exp_b = exp_bursts.pop_front();
                assert (burst_req == exp_b) else value_error("burst_req_o", burst_req, exp_b);
                due = cycle + 1 + ($random(seed) & 7);
                if (due <= last_due) begin
                    due = last_due + 1;
                end
                last_due = due;
                done_due.push_back(due);
            end
            if (acc_res_valid && acc_res_ready) begin
                assert (exp_res.size() > 0) else plain_error("unexpected response issued");
                exp_r = exp_res.pop_front();
                assert (acc_res == exp_r) else value_error("acc_res_o", acc_res, exp_r);
            end
            burst_stall = burst_valid && !burst_ready;
            held_burst  = burst_req;
            res_stall   = acc_res_valid && !acc_res_ready;
            held_res    = acc_res;
        end
    end

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------
    initial begin
        bit acked;
        int n;
        acc_req       = '0;
        acc_req_valid = 1'b0;
        acc_res_ready = 1'b1;
        tag           = '0;
        mdl_job       = '0;
        mdl_next_id   = 32'd1;
        mdl_completed = '0;
        mdl_queued    = 0;

        n = 0;
        while (rst_n !== 1'b1 && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (n >= TIMEOUT) begin
            plain_error("reset was never released");
        end
        @(negedge clk);
        assert (!acc_res_valid && !burst_valid && !busy && !acc_req_ready)
            else plain_error("outputs not idle after reset");

        // reset values of the ID counters
        instr(OP_STATI, 2'd1, 32'h0, 32'h0);
        instr(OP_STATI, 2'd0, 32'h0, 32'h0);
        wait_idle();

        // single 1D copy
        instr(OP_SRC, 2'd0, 32'h0000_1000, 32'h0);
        instr(OP_DST, 2'd0, 32'h0000_8000, 32'h0);
        instr(OP_CPY, 2'd0, 32'h0000_0040, 32'h0);
        wait_idle();

        // 2D copy from the immediate then 1D with reps still programmed
        instr(OP_STR, 2'd0, 32'h0000_0100, 32'h0000_0240);
        instr(OP_REP, 2'd0, 32'd4, 32'h0);
        instr(OP_SRC, 2'd0, 32'h0000_2000, 32'h0);
        instr(OP_DST, 2'd0, 32'h0000_9000, 32'h0);
        instr(OP_CPYI, 2'd2, 32'h0000_0020, 32'h0);
        instr(OP_CPY, 2'd0, 32'h0000_0010, 32'h0);
        wait_idle();

        // completion status from argb
        instr(OP_STAT, 2'd0, 32'h0, 32'd0);
        instr(OP_STAT, 2'd0, 32'h0, 32'd2);
        wait_idle();

        // response stall fills both spill entries and blocks further acks
        acc_res_ready = 1'b0;
        instr(OP_STATI, 2'd1, 32'h0, 32'h0);
        instr(OP_STATI, 2'd0, 32'h0, 32'h0);
        issue_req(OP_STATI, 2'd2, 32'h0, 32'h0, 6, acked);
        assert (!acked) else plain_error("status acknowledged with the response buffer full");
        repeat (4) @(negedge clk);
        acc_res_ready = 1'b1;
        wait_idle();

        // burst stall fills the job queue behind the active job
        burst_hold = 1'b1;
        @(negedge clk);
        instr(OP_REP, 2'd0, 32'd3, 32'h0);
        instr(OP_STR, 2'd0, 32'h0000_0040, 32'h0000_0080);
        instr(OP_SRC, 2'd0, 32'h0000_3000, 32'h0);
        instr(OP_DST, 2'd0, 32'h0000_a000, 32'h0);
        instr(OP_CPY, 2'd0, 32'h0000_0008, 32'd2);
        instr(OP_SRC, 2'd0, 32'h0000_4000, 32'h0);
        instr(OP_CPY, 2'd0, 32'h0000_0018, 32'd0);
        instr(OP_SRC, 2'd0, 32'h0000_5000, 32'h0);
        instr(OP_CPYI, 2'd0, 32'h0000_0028, 32'h0);
        instr(OP_SRC, 2'd0, 32'h0000_6000, 32'h0);
        instr(OP_CPY, 2'd0, 32'h0000_0038, 32'd0);
        mdl_queued = `DMA_FIFO_DEPTH;
        instr(OP_STATI, 2'd3, 32'h0, 32'h0);
        issue_req(OP_CPY, 2'd0, 32'h0000_0048, 32'd0, 6, acked);
        assert (!acked) else plain_error("copy acknowledged with the job queue full");
        // jobs are queued and in flight
        instr(OP_STATI, 2'd2, 32'h0, 32'h0);
        assert (busy === 1'b1) else value_error("busy_o", busy, 1'b1);
        mdl_queued = 0;
        burst_hold = 1'b0;
        wait_idle();

        instr(OP_STAT, 2'd0, 32'h0, 32'd0);
        instr(OP_STATI, 2'd2, 32'h0, 32'h0);
        wait_idle();

        $display("NO ERRORS");
        $finish;
    end

endmodule

/* dma_frontend.f */
+incdir+.
acc_pkg.sv
dma_pkg.sv
dma_inst_decoder.sv
dma_req_fifo.sv
dma_nd_midend.sv
dma_tf_id_gen.sv
dma_rsp_spill.sv
dma_frontend_top.sv
tb_clk_gen.sv
tb_dma_frontend.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the DMA frontend testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module tb_dma_frontend -f dma_frontend.f -o sim_dma_frontend
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed"
    exit $status
fi

./obj_dir/sim_dma_frontend
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed"
    exit $status
fi

exit 0
